// File: Bender.yml
package:
  name: ahb_fir_slave

sources:
  - fir_ahb_pkg.sv
  - ahb_data_phase_decode.sv
  - fir_config_regs.sv
  - fir_read_mux.sv
  - ahb_fir_slave.sv
  - target: test
    files:
      - fir_slave_checker.sv
      - tb_ahb_fir_slave.sv

// File: ahb_data_phase_decode.sv
//****************************
// AHB address phase decode
//****************************

`timescale 1ns/1ps

module ahb_data_phase_decode import fir_ahb_pkg::*; (
  input  logic              tb_clk,
  input  logic              rst_n,
  // Address phase inputs
  input  logic              hsel,
  input  ahb_trans_e        htrans,
  input  logic [ADDR_W-1:0] haddr,
  input  logic [2:0]        hsize,
  input  logic              hwrite,
  // Data phase controls
  output logic              wr_en,
  output reg_sel_e          wr_sel,
  output reg_sel_e          rd_sel,
  output logic              hresp
);

  logic     addr_valid;
  logic     illegal;
  reg_sel_e addr_sel;

  //****************************
  // Address phase
  //****************************
  // Valid transfer: selected and NONSEQ or SEQ
  assign addr_valid = hsel && ((htrans == NONSEQ) || (htrans == SEQ));

  // Map byte address to register
  always_comb begin
    case (haddr)
      ADDR_STATUS:               addr_sel = REG_STATUS;
      ADDR_RESULT:               addr_sel = REG_RESULT;
      ADDR_SAMPLE:               addr_sel = REG_SAMPLE;
      ADDR_COEF_BASE:            addr_sel = REG_COEF0;
      ADDR_COEF_BASE + ADDR_W'(2): addr_sel = REG_COEF1;
      ADDR_COEF_BASE + ADDR_W'(4): addr_sel = REG_COEF2;
      ADDR_COEF_BASE + ADDR_W'(6): addr_sel = REG_COEF3;
      ADDR_COEF_SET:             addr_sel = REG_COEF_SET;
      // Odd addresses land here
      default:                   addr_sel = REG_NONE;
    endcase
  end

  // Rejected transfers
  // Wrong size, unaligned, or a write to a read-only register
  always_comb begin
    illegal = 1'b0;
    if (hsize != HSIZE_HALF) begin
      illegal = 1'b1;
    end
    if (haddr[0]) begin
      illegal = 1'b1;
    end
    if (hwrite && ((addr_sel == REG_STATUS) || (addr_sel == REG_RESULT))) begin
      illegal = 1'b1;
    end
  end

  //****************************
  // Data phase registers
  //****************************
  // Reloaded every cycle, so each result lasts one data phase only
  always_ff @(posedge tb_clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_en  <= 1'b0;
      wr_sel <= REG_NONE;
      rd_sel <= REG_NONE;
      hresp  <= 1'b0;
    end else begin
      // Legal write
      wr_en  <= addr_valid && hwrite && !illegal;
      wr_sel <= addr_sel;
      // Legal read, otherwise the mux returns zero
      if (addr_valid && !hwrite && !illegal) begin
        rd_sel <= addr_sel;
      end else begin
        rd_sel <= REG_NONE;
      end
      // Error response
      hresp  <= addr_valid && illegal;
    end
  end

  //****************************
  // Checks
  //****************************
  // A rejected write never reaches the registers
  a_no_write_on_error: assert property (
    @(posedge tb_clk) disable iff (!rst_n)
    (hsel && ((htrans == NONSEQ) || (htrans == SEQ)) && hwrite &&
     ((hsize != HSIZE_HALF) || haddr[0] ||
      (haddr == ADDR_STATUS) || (haddr == ADDR_RESULT)))
    |=> (hresp && !wr_en)
  );

  // Error response is one cycle unless another bad access follows
  a_hresp_one_cycle: assert property (
    @(posedge tb_clk) disable iff (!rst_n)
    (hresp && !(addr_valid && illegal)) |=> !hresp
  );

endmodule

// File: ahb_fir_slave.sv
//****************************
// AHB-Lite FIR register slave
//****************************

`timescale 1ns/1ps

module ahb_fir_slave import fir_ahb_pkg::*; (
  input  logic                  tb_clk,
  input  logic                  rst_n,
  // AHB-Lite slave side
  input  logic                  hsel,
  input  ahb_trans_e            htrans,
  input  logic [ADDR_W-1:0]     haddr,
  input  logic [2:0]            hsize,
  input  logic                  hwrite,
  input  logic [DATA_W-1:0]     hwdata,
  output logic [DATA_W-1:0]     hrdata,
  output logic                  hresp,
  // From the filter and coefficient loader
  input  logic [DATA_W-1:0]     fir_out,
  input  logic                  modwait,
  input  logic                  err,
  input  logic [COEF_IDX_W-1:0] coefficient_num,
  // To the filter and coefficient loader
  output logic [DATA_W-1:0]     sample_data,
  output logic                  data_ready,
  output logic [DATA_W-1:0]     fir_coefficient,
  output logic                  new_coefficient_set
);

  // Data phase controls
  logic                            wr_en;
  reg_sel_e                        wr_sel;
  reg_sel_e                        rd_sel;
  // Coefficient readback
  logic [NUM_COEF-1:0][DATA_W-1:0] coef_regs;

  //****************************
  // Bus decode
  //****************************
  ahb_data_phase_decode u_decode (
    .tb_clk (tb_clk),
    .rst_n  (rst_n),
    .hsel   (hsel),
    .htrans (htrans),
    .haddr  (haddr),
    .hsize  (hsize),
    .hwrite (hwrite),
    .wr_en  (wr_en),
    .wr_sel (wr_sel),
    .rd_sel (rd_sel),
    .hresp  (hresp)
  );

  //****************************
  // Registers and flags
  //****************************
  fir_config_regs u_regs (
    .tb_clk              (tb_clk),
    .rst_n               (rst_n),
    .wr_en               (wr_en),
    .wr_sel              (wr_sel),
    .hwdata              (hwdata),
    .modwait             (modwait),
    .coefficient_num     (coefficient_num),
    .sample_data         (sample_data),
    .data_ready          (data_ready),
    .new_coefficient_set (new_coefficient_set),
    .fir_coefficient     (fir_coefficient),
    .coef_regs           (coef_regs)
  );

  // Read path
  fir_read_mux u_read_mux (
    .rd_sel              (rd_sel),
    .sample_data         (sample_data),
    .coef_regs           (coef_regs),
    .new_coefficient_set (new_coefficient_set),
    .fir_out             (fir_out),
    .modwait             (modwait),
    .err                 (err),
    .hrdata              (hrdata)
  );

endmodule

// File: fir_ahb_pkg.sv
//****************************
// AHB FIR slave shared types
//****************************

package fir_ahb_pkg;

  //****************************
  // Widths
  //****************************
  // Bus data and register width
  localparam int DATA_W     = 16;
  // Byte address into the register block
  localparam int ADDR_W     = 4;
  // Filter taps
  localparam int NUM_COEF   = 4;
  localparam int COEF_IDX_W = 2;

  //****************************
  // Register address map
  //****************************
  // Byte addresses, all halfword aligned
  localparam logic [ADDR_W-1:0] ADDR_STATUS    = ADDR_W'(0);
  localparam logic [ADDR_W-1:0] ADDR_RESULT    = ADDR_W'(2);
  localparam logic [ADDR_W-1:0] ADDR_SAMPLE    = ADDR_W'(4);
  // F0 here, F1 to F3 follow in steps of 2
  localparam logic [ADDR_W-1:0] ADDR_COEF_BASE = ADDR_W'(6);
  localparam logic [ADDR_W-1:0] ADDR_COEF_SET  = ADDR_W'(14);

  // Status word bit positions
  localparam int STATUS_BUSY_BIT = 0;
  localparam int STATUS_ERR_BIT  = 8;

  //****************************
  // Bus encodings
  //****************************
  // Only halfword transfers are legal
  localparam logic [2:0] HSIZE_HALF = 3'b001;

  // AHB transfer type
  typedef enum logic [1:0] {
    IDLE   = 2'b00,
    BUSY   = 2'b01,
    NONSEQ = 2'b10,
    SEQ    = 2'b11
  } ahb_trans_e;

  // Decoded register select
  typedef enum logic [3:0] {
    REG_STATUS   = 4'd0,
    REG_RESULT   = 4'd1,
    REG_SAMPLE   = 4'd2,
    REG_COEF0    = 4'd3,
    REG_COEF1    = 4'd4,
    REG_COEF2    = 4'd5,
    REG_COEF3    = 4'd6,
    REG_COEF_SET = 4'd7,
    // No register, or an access that was rejected
    REG_NONE     = 4'd15
  } reg_sel_e;

endpackage

// File: fir_config_regs.sv
//****************************
// FIR configuration registers
//****************************

`timescale 1ns/1ps

module fir_config_regs import fir_ahb_pkg::*; (
  input  logic                             tb_clk,
  input  logic                             rst_n,
  // Data phase write
  input  logic                             wr_en,
  input  reg_sel_e                         wr_sel,
  input  logic [DATA_W-1:0]                hwdata,
  // Filter and coefficient loader side
  input  logic                             modwait,
  input  logic [COEF_IDX_W-1:0]            coefficient_num,
  output logic [DATA_W-1:0]                sample_data,
  output logic                             data_ready,
  output logic                             new_coefficient_set,
  output logic [DATA_W-1:0]                fir_coefficient,
  // Coefficient values for readback
  output logic [NUM_COEF-1:0][DATA_W-1:0]  coef_regs
);

  logic sample_wr;
  logic coef_set_wr;
  logic load_done;

  // Write strobes per register
  assign sample_wr   = wr_en && (wr_sel == REG_SAMPLE);
  assign coef_set_wr = wr_en && (wr_sel == REG_COEF_SET);

  // Loader has reached the last tap and is idle
  assign load_done = new_coefficient_set &&
                     (coefficient_num == COEF_IDX_W'(NUM_COEF - 1)) &&
                     !modwait;

  //****************************
  // Sample register
  //****************************
  always_ff @(posedge tb_clk or negedge rst_n) begin
    if (!rst_n) begin
      sample_data <= '0;
    end else if (sample_wr) begin
      sample_data <= hwdata;
    end
  end

  // New sample flag
  // Set by the write, dropped once the filter starts work
  always_ff @(posedge tb_clk or negedge rst_n) begin
    if (!rst_n) begin
      data_ready <= 1'b0;
    end else if (sample_wr) begin
      data_ready <= 1'b1;
    end else if (modwait) begin
      data_ready <= 1'b0;
    end
  end

  //****************************
  // Coefficient registers
  //****************************
  always_ff @(posedge tb_clk or negedge rst_n) begin
    if (!rst_n) begin
      coef_regs <= '0;
    end else if (wr_en) begin
      case (wr_sel)
        REG_COEF0: coef_regs[0] <= hwdata;
        REG_COEF1: coef_regs[1] <= hwdata;
        REG_COEF2: coef_regs[2] <= hwdata;
        REG_COEF3: coef_regs[3] <= hwdata;
        // Other registers live elsewhere
        default: ;
      endcase
    end
  end

  // Loader picks one tap at a time
  assign fir_coefficient = coef_regs[coefficient_num];

  //****************************
  // Coefficient set flag
  //****************************
  // Any nonzero write confirms, a zero write withdraws
  always_ff @(posedge tb_clk or negedge rst_n) begin
    if (!rst_n) begin
      new_coefficient_set <= 1'b0;
    end else if (coef_set_wr) begin
      new_coefficient_set <= |hwdata;
    end else if (load_done) begin
      new_coefficient_set <= 1'b0;
    end
  end

  //****************************
  // Checks
  //****************************
  // data_ready only rises on the edge after a sample write phase
  a_ready_after_sample: assert property (
    @(posedge tb_clk) disable iff (!rst_n)
    $rose(data_ready) |-> $past(wr_en && (wr_sel == REG_SAMPLE))
  );

endmodule

// File: fir_read_mux.sv
//****************************
// AHB read data mux
//****************************

`timescale 1ns/1ps

module fir_read_mux import fir_ahb_pkg::*; (
  // Captured read select
  input  reg_sel_e                         rd_sel,
  // Register contents
  input  logic [DATA_W-1:0]                sample_data,
  input  logic [NUM_COEF-1:0][DATA_W-1:0]  coef_regs,
  input  logic                             new_coefficient_set,
  // Filter status and result
  input  logic [DATA_W-1:0]                fir_out,
  input  logic                             modwait,
  input  logic                             err,
  // Read data
  output logic [DATA_W-1:0]                hrdata
);

  logic [DATA_W-1:0] status_word;
  logic [DATA_W-1:0] coef_set_word;

  //****************************
  // Status word
  //****************************
  // Busy while filtering or while a coefficient load is pending
  always_comb begin
    status_word                  = '0;
    status_word[STATUS_BUSY_BIT] = modwait || new_coefficient_set;
    status_word[STATUS_ERR_BIT]  = err;
  end

  // Confirmation flag reads back in bit 0
  always_comb begin
    coef_set_word    = '0;
    coef_set_word[0] = new_coefficient_set;
  end

  //****************************
  // Read select
  //****************************
  always_comb begin
    case (rd_sel)
      REG_STATUS:   hrdata = status_word;
      // Live filter output
      REG_RESULT:   hrdata = fir_out;
      REG_SAMPLE:   hrdata = sample_data;
      REG_COEF0:    hrdata = coef_regs[0];
      REG_COEF1:    hrdata = coef_regs[1];
      REG_COEF2:    hrdata = coef_regs[2];
      REG_COEF3:    hrdata = coef_regs[3];
      REG_COEF_SET: hrdata = coef_set_word;
      // No read or rejected access
      default:      hrdata = '0;
    endcase
  end

endmodule

// File: fir_slave_checker.sv
//****************************
// FIR slave response checker
//****************************

`timescale 1ns/1ps

module fir_slave_checker import fir_ahb_pkg::*; (
  input  logic                  tb_clk,
  input  logic                  rst_n,
  // Bus pins
  input  logic                  hsel,
  input  ahb_trans_e            htrans,
  input  logic [ADDR_W-1:0]     haddr,
  input  logic [2:0]            hsize,
  input  logic                  hwrite,
  input  logic [DATA_W-1:0]     hwdata,
  input  logic [DATA_W-1:0]     hrdata,
  input  logic                  hresp,
  // Filter side
  input  logic                  modwait,
  input  logic [COEF_IDX_W-1:0] coefficient_num,
  input  logic [DATA_W-1:0]     sample_data,
  input  logic                  data_ready,
  input  logic [DATA_W-1:0]     fir_coefficient,
  input  logic                  new_coefficient_set,
  // Expected values, valid while chk_en is high
  input  logic                  chk_en,
  input  logic [DATA_W-1:0]     exp_hrdata,
  input  logic                  exp_hresp,
  input  logic [DATA_W-1:0]     exp_sample,
  input  logic [DATA_W-1:0]     exp_coef,
  output int                    check_count,
  output int                    error_count
);

  logic legal_wr;
  logic ph_sample_wr;
  logic ph_coef_set_wr;
  logic model_ready;
  logic model_coef_set;

  // Aligned halfword write in a valid address phase
  assign legal_wr = hsel && ((htrans == NONSEQ) || (htrans == SEQ)) && hwrite &&
                    (hsize == HSIZE_HALF) && !haddr[0];

  //****************************
  // Flag model
  //****************************
  always_ff @(posedge tb_clk or negedge rst_n) begin
    if (!rst_n) begin
      ph_sample_wr   <= 1'b0;
      ph_coef_set_wr <= 1'b0;
      model_ready    <= 1'b0;
      model_coef_set <= 1'b0;
    end else begin
      ph_sample_wr   <= legal_wr && (haddr == ADDR_SAMPLE);
      ph_coef_set_wr <= legal_wr && (haddr == ADDR_COEF_SET);
      // Sample write completes now, else modwait clears
      if (ph_sample_wr) begin
        model_ready <= 1'b1;
      end else if (modwait) begin
        model_ready <= 1'b0;
      end
      // Loader done at the last tap with modwait low
      if (ph_coef_set_wr) begin
        model_coef_set <= (hwdata != '0);
      end else if (model_coef_set && (coefficient_num == COEF_IDX_W'(NUM_COEF - 1)) &&
                   !modwait) begin
        model_coef_set <= 1'b0;
      end
    end
  end

  task automatic compare_value(input string what, input logic [DATA_W-1:0] got,
                               input logic [DATA_W-1:0] want);
    check_count++;
    if (got !== want) begin
      error_count++;
      $display("ERR %0t: %s is %h, expected %h", $time, what, got, want);
    end
  endtask

  initial begin
    check_count = 0;
    error_count = 0;
  end

  // Mid-cycle sampling, away from the driving edge
  always @(negedge tb_clk) begin
    compare_value("data_ready", data_ready, model_ready);
    compare_value("new_coefficient_set", new_coefficient_set, model_coef_set);
    // Reset state while the filter inputs are held active
    if (!rst_n) begin
      compare_value("hresp", hresp, '0);
      compare_value("hrdata", hrdata, '0);
      compare_value("sample_data", sample_data, '0);
      compare_value("fir_coefficient", fir_coefficient, '0);
    end
    if (chk_en) begin
      compare_value("hrdata", hrdata, exp_hrdata);
      compare_value("hresp", hresp, exp_hresp);
      compare_value("sample_data", sample_data, exp_sample);
      compare_value("fir_coefficient", fir_coefficient, exp_coef);
    end
  end

endmodule

// File: project.f
fir_ahb_pkg.sv
ahb_data_phase_decode.sv
fir_config_regs.sv
fir_read_mux.sv
ahb_fir_slave.sv
fir_slave_checker.sv
tb_ahb_fir_slave.sv

// File: tb_ahb_fir_slave.sv
//****************************
// AHB FIR slave testbench
//****************************

`timescale 1ns/1ps

module tb_ahb_fir_slave import fir_ahb_pkg::*; ();

  localparam int CLK_PERIOD     = 4;
  localparam int RESET_CYCLES   = 8;
  localparam int NUM_ROWS       = 26;
  // Each row takes two bus cycles, so this bound is generous
  localparam int TIMEOUT_CYCLES = NUM_ROWS * 6 + RESET_CYCLES + 50;
  // Byte size, rejected by the slave
  localparam logic [2:0] HSIZE_BYTE = 3'b000;

  typedef enum logic [1:0] {OP_IDLE, OP_WR, OP_RD} tb_op_e;

  // One stimulus row with its expected responses
  typedef struct packed {
    tb_op_e                  op;
    logic [ADDR_W-1:0]       haddr;
    logic [2:0]              hsize;
    logic [DATA_W-1:0]       hwdata;
    logic [DATA_W-1:0]       fir_out;
    logic                    modwait;
    logic                    err;
    logic [COEF_IDX_W-1:0]   coef_num;
    logic [DATA_W-1:0]       exp_hrdata;
    logic                    exp_hresp;
    logic [DATA_W-1:0]       exp_sample;
    logic [DATA_W-1:0]       exp_coef;
  } row_t;

  logic                  tb_clk;
  logic                  rst_n;
  // Bus pins
  logic                  hsel;
  ahb_trans_e            htrans;
  logic [ADDR_W-1:0]     haddr;
  logic [2:0]            hsize;
  logic                  hwrite;
  logic [DATA_W-1:0]     hwdata;
  logic [DATA_W-1:0]     hrdata;
  logic                  hresp;
  // Filter side
  logic [DATA_W-1:0]     fir_out;
  logic                  modwait;
  logic                  err;
  logic [COEF_IDX_W-1:0] coefficient_num;
  logic [DATA_W-1:0]     sample_data;
  logic                  data_ready;
  logic [DATA_W-1:0]     fir_coefficient;
  logic                  new_coefficient_set;
  // Expected values for the current data phase
  logic                  chk_en;
  logic [DATA_W-1:0]     exp_hrdata;
  logic                  exp_hresp;
  logic [DATA_W-1:0]     exp_sample;
  logic [DATA_W-1:0]     exp_coef;
  int                    check_count;
  int                    error_count;
  // Stimulus table and the register state it implies
  row_t                            rows [NUM_ROWS];
  int                              row_count;
  integer                          seed;
  logic [31:0]                     rand_word;
  logic [DATA_W-1:0]               model_sample;
  logic [NUM_COEF-1:0][DATA_W-1:0] model_coef;
  logic [NUM_COEF-1:0][DATA_W-1:0] coef_rand;

  initial tb_clk = 1'b0;
  always #(CLK_PERIOD / 2) tb_clk = ~tb_clk;

  ahb_fir_slave uut (.*);
  fir_slave_checker u_checker (.*);

  //****************************
  // Table building
  //****************************
  // Row expects sample and coefficient as left by earlier rows
  task automatic add_row(input tb_op_e op, input logic [ADDR_W-1:0] addr,
                         input logic [2:0] size, input logic [DATA_W-1:0] data,
                         input logic [DATA_W-1:0] fout, input logic mwait,
                         input logic ferr, input logic [COEF_IDX_W-1:0] cnum,
                         input logic [DATA_W-1:0] exp_rd, input logic exp_resp);
    // Field order follows row_t
    rows[row_count] = {op, addr, size, data, fout, mwait, ferr, cnum,
                       exp_rd, exp_resp, model_sample, model_coef[cnum]};
    // Only aligned halfword writes land in a register
    if (op == OP_WR && size == HSIZE_HALF && !addr[0]) begin
      if (addr == ADDR_SAMPLE) begin
        model_sample = data;
      end else if (addr >= ADDR_COEF_BASE && addr < ADDR_COEF_SET) begin
        model_coef[(addr - ADDR_COEF_BASE) >> 1] = data;
      end
    end
    row_count++;
  endtask

  //****************************
  // Stimulus
  //****************************
  initial begin
    // Reset with the filter inputs active
    rst_n = 1'b0;
    hsel = 1'b0;
    htrans = IDLE;
    haddr = '0;
    hsize = HSIZE_HALF;
    hwrite = 1'b0;
    hwdata = '0;
    fir_out = 16'h1234;
    modwait = 1'b1;
    err = 1'b1;
    coefficient_num = 2'd2;
    chk_en = 1'b0;
    exp_hrdata = '0;
    exp_hresp = 1'b0;
    exp_sample = '0;
    exp_coef = '0;
    seed = 25;
    row_count = 0;
    model_sample = '0;
    model_coef = '0;

    // Status just after reset, busy from modwait and error from err
    add_row(OP_RD, ADDR_STATUS, HSIZE_HALF, 16'h0, 16'h1234, 1'b1, 1'b1, 2'd2, 16'h0101, 1'b0);
    // Sample write, readback, then modwait drops data_ready
    add_row(OP_WR, ADDR_SAMPLE, HSIZE_HALF, 16'hA5C3, 16'h1234, 1'b0, 1'b0, 2'd0, 16'h0, 1'b0);
    add_row(OP_RD, ADDR_SAMPLE, HSIZE_HALF, 16'h0, 16'h1234, 1'b0, 1'b0, 2'd0, 16'hA5C3, 1'b0);
    add_row(OP_IDLE, ADDR_STATUS, HSIZE_HALF, 16'h0, 16'h1234, 1'b1, 1'b0, 2'd0, 16'h0, 1'b0);
    // Random coefficients F0 to F3
    for (int i = 0; i < NUM_COEF; i++) begin
      rand_word = $random(seed);
      coef_rand[i] = rand_word[DATA_W-1:0];
      add_row(OP_WR, ADDR_COEF_BASE + ADDR_W'(2 * i), HSIZE_HALF, coef_rand[i], 16'h1234,
              1'b0, 1'b0, 2'd0, 16'h0, 1'b0);
    end
    // Readback, with the loader index on the same tap
    for (int i = 0; i < NUM_COEF; i++) begin
      add_row(OP_RD, ADDR_COEF_BASE + ADDR_W'(2 * i), HSIZE_HALF, 16'h0, 16'h1234,
              1'b0, 1'b0, COEF_IDX_W'(i), coef_rand[i], 1'b0);
    end
    // Confirmation raises busy until the loader reaches tap 3
    add_row(OP_WR, ADDR_COEF_SET, HSIZE_HALF, 16'h0001, 16'h1234, 1'b0, 1'b0, 2'd0, 16'h0, 1'b0);
    add_row(OP_RD, ADDR_STATUS, HSIZE_HALF, 16'h0, 16'h1234, 1'b0, 1'b0, 2'd0, 16'h0001, 1'b0);
    add_row(OP_RD, ADDR_COEF_SET, HSIZE_HALF, 16'h0, 16'h1234, 1'b0, 1'b0, 2'd0, 16'h0001, 1'b0);
    add_row(OP_IDLE, ADDR_STATUS, HSIZE_HALF, 16'h0, 16'h1234, 1'b0, 1'b0, 2'd3, 16'h0, 1'b0);
    add_row(OP_RD, ADDR_COEF_SET, HSIZE_HALF, 16'h0, 16'h1234, 1'b0, 1'b0, 2'd0, 16'h0, 1'b0);
    add_row(OP_RD, ADDR_STATUS, HSIZE_HALF, 16'h0, 16'h1234, 1'b0, 1'b0, 2'd0, 16'h0, 1'b0);
    // Live result, then rejected accesses
    add_row(OP_RD, ADDR_RESULT, HSIZE_HALF, 16'h0, 16'h7E11, 1'b0, 1'b0, 2'd0, 16'h7E11, 1'b0);
    add_row(OP_WR, ADDR_STATUS, HSIZE_HALF, 16'hFFFF, 16'h7E11, 1'b0, 1'b0, 2'd0, 16'h0, 1'b1);
    add_row(OP_WR, ADDR_RESULT, HSIZE_HALF, 16'hFFFF, 16'h7E11, 1'b0, 1'b0, 2'd0, 16'h0, 1'b1);
    add_row(OP_WR, 4'd5, HSIZE_HALF, 16'h1111, 16'h7E11, 1'b0, 1'b0, 2'd0, 16'h0, 1'b1);
    add_row(OP_RD, 4'd7, HSIZE_HALF, 16'h0, 16'h7E11, 1'b0, 1'b0, 2'd0, 16'h0, 1'b1);
    add_row(OP_WR, ADDR_SAMPLE, HSIZE_BYTE, 16'h2222, 16'h7E11, 1'b0, 1'b0, 2'd0, 16'h0, 1'b1);
    // Sample untouched by the rejected writes
    add_row(OP_RD, ADDR_SAMPLE, HSIZE_HALF, 16'h0, 16'h7E11, 1'b0, 1'b0, 2'd0, 16'hA5C3, 1'b0);
    add_row(OP_RD, ADDR_STATUS, HSIZE_HALF, 16'h0, 16'h7E11, 1'b0, 1'b1, 2'd0, 16'h0100, 1'b0);

    repeat (RESET_CYCLES) @(posedge tb_clk);
    rst_n <= 1'b1;

    for (int i = 0; i < row_count; i++) begin
      @(posedge tb_clk);
      // Address phase and filter inputs
      hsel            <= (rows[i].op != OP_IDLE);
      htrans          <= (rows[i].op != OP_IDLE) ? NONSEQ : IDLE;
      haddr           <= rows[i].haddr;
      hsize           <= rows[i].hsize;
      hwrite          <= (rows[i].op == OP_WR);
      fir_out         <= rows[i].fir_out;
      modwait         <= rows[i].modwait;
      err             <= rows[i].err;
      coefficient_num <= rows[i].coef_num;
      chk_en          <= 1'b0;
      @(posedge tb_clk);
      // Data phase, bus idle behind it
      hsel       <= 1'b0;
      htrans     <= IDLE;
      hwdata     <= rows[i].hwdata;
      chk_en     <= 1'b1;
      exp_hrdata <= rows[i].exp_hrdata;
      exp_hresp  <= rows[i].exp_hresp;
      exp_sample <= rows[i].exp_sample;
      exp_coef   <= rows[i].exp_coef;
    end
    @(posedge tb_clk);
    chk_en <= 1'b0;
    repeat (2) @(posedge tb_clk);

    $display("Summary: %0d rows, %0d checks, %0d errors", row_count, check_count, error_count);
    if (error_count == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

  // Watchdog
  initial begin
    #(TIMEOUT_CYCLES * CLK_PERIOD);
    $display("Timeout: run did not finish within %0d clock periods", TIMEOUT_CYCLES);
    $display("FAIL: see errors above");
    $finish;
  end

endmodule
